/* src/saa_pkg.sv */
package saa_pkg;

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////

    // bus data byte, also one audio output sample
    typedef logic [7:0] byte_t;

    // amplitude of one side of a channel
    typedef logic [3:0] amp_t;

    // channel level on one side, tone plus noise gives up to 2x amplitude
    typedef logic [4:0] level_t;

    typedef logic [2:0] octave_t;

    // divider terminal count, 510 minus the written byte
    typedef logic [8:0] freq_t;

    // 0..2 fixed rates, 3 follows the tone generator carry
    typedef logic [1:0] noise_sel_t;

    //////////////////////////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  cs_n;
        logic  a0;
        logic  wr_n;
        byte_t din;
    } saa_bus_t;

    typedef struct packed {
        amp_t    amp_l;
        amp_t    amp_r;
        octave_t octave;
        freq_t   freq;
        logic    tone_en;
        logic    noise_en;
    } chan_cfg_t;

    typedef struct packed {
        chan_cfg_t  [5:0] chan;
        noise_sel_t [1:0] noise_sel;
        logic             sound_en;
        logic             sync;
    } saa_cfg_t;

    // output curve, slope halves above the knee
    localparam byte_t COMP_KNEE = 8'd64;

    localparam logic [30:0] DEFAULT_SEED = 31'h11111111;

endpackage

/* src/saa_regfile.sv */
module saa_regfile import saa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  saa_bus_t bus,
    output saa_cfg_t cfg
);

    logic [4:0]  addr_q;
    byte_t [5:0] amp_q;
    freq_t [5:0] freq_q;
    byte_t [2:0] oct_q;
    byte_t       freq_en_q;
    byte_t       noise_en_q;
    byte_t       noise_gen_q;
    byte_t       env0_q;
    byte_t       env1_q;
    byte_t       ctrl_q;

    logic        wr;
    logic [5:0]  tone_block;

    assign wr = !bus.cs_n && !bus.wr_n;

    //////////////////////////////////////////////////////////////////////
    // address latch and register writes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q      <= '0;
            amp_q       <= '0;
            freq_q      <= '0;
            oct_q       <= '0;
            freq_en_q   <= '0;
            noise_en_q  <= '0;
            noise_gen_q <= '0;
            env0_q      <= '0;
            env1_q      <= '0;
            ctrl_q      <= '0;
        end else if (wr) begin
            if (bus.a0) begin
                addr_q <= bus.din[4:0];
            end else begin
                case (addr_q)
                    5'h00, 5'h01, 5'h02, 5'h03, 5'h04, 5'h05:
                        amp_q[addr_q[2:0]] <= bus.din;
                    // stored as terminal count of the divider
                    5'h08, 5'h09, 5'h0a, 5'h0b, 5'h0c, 5'h0d:
                        freq_q[addr_q[2:0]] <= 9'd510 - {1'b0, bus.din};
                    5'h10, 5'h11, 5'h12:
                        oct_q[addr_q[1:0]] <= bus.din;
                    5'h14: freq_en_q   <= bus.din;
                    5'h15: noise_en_q  <= bus.din;
                    5'h16: noise_gen_q <= bus.din;
                    5'h18: env0_q      <= bus.din;
                    5'h19: env1_q      <= bus.din;
                    5'h1c: ctrl_q      <= bus.din;
                    default: ;
                endcase
            end
        end
    end

    // gens 0 and 3 lose tone duty when clocking noise,
    // gens 1 and 4 when the envelope claims them
    assign tone_block = {1'b0, env1_q[7], noise_gen_q[5:4] == 2'd3,
                         1'b0, env0_q[7], noise_gen_q[1:0] == 2'd3};

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            cfg.chan[i].amp_l    = amp_q[i][3:0];
            cfg.chan[i].amp_r    = amp_q[i][7:4];
            cfg.chan[i].octave   = oct_q[i / 2][(i % 2) * 4 +: 3];
            cfg.chan[i].freq     = freq_q[i];
            cfg.chan[i].tone_en  = freq_en_q[i] && !tone_block[i];
            cfg.chan[i].noise_en = noise_en_q[i];
        end
        cfg.noise_sel[0] = noise_gen_q[1:0];
        cfg.noise_sel[1] = noise_gen_q[5:4];
        cfg.sound_en     = ctrl_q[0];
        cfg.sync         = ctrl_q[1];
    end

endmodule

/* src/saa_tone_gen.sv */
module saa_tone_gen import saa_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sync,
    input  octave_t octave,
    input  freq_t   freq,
    output logic    tone,
    output logic    carry
);

    logic [7:0] pre_cnt;
    logic [7:0] pre_last;
    logic       pre_pulse;
    freq_t      div_cnt;

    // prescaler period is 256 >> octave cycles
    assign pre_last  = 8'hff >> octave;
    assign pre_pulse = (pre_cnt == pre_last);

    always_ff @(posedge clk) begin
        if (!rst_n || sync) begin
            pre_cnt <= '0;
        end else if (pre_pulse) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 8'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // frequency divider
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || sync) begin
            div_cnt <= '0;
            tone    <= 1'b0;
        end else if (pre_pulse) begin
            if (div_cnt == freq) begin
                div_cnt <= '0;
                tone    <= !tone;
            end else begin
                div_cnt <= div_cnt + 9'd1;
            end
        end
    end

    // one cycle wide, only on a prescaler pulse
    assign carry = pre_pulse && (div_cnt == freq);

endmodule

/* src/saa_noise_gen.sv */
module saa_noise_gen import saa_pkg::*; #(
    parameter logic [30:0] SEED = DEFAULT_SEED
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       carry,
    input  noise_sel_t sel,
    output logic       noise
);

    logic [9:0]  rate_cnt;
    logic [9:0]  rate_last;
    logic        rate_tick;
    logic        step;
    logic [30:0] lfsr;

    always_comb begin
        case (sel)
            2'd0:    rate_last = 10'd255;
            2'd1:    rate_last = 10'd511;
            default: rate_last = 10'd1023;
        endcase
    end

    // >= so a switch to a faster rate does not run the counter around
    assign rate_tick = (rate_cnt >= rate_last);

    always_ff @(posedge clk) begin
        if (!rst_n || rate_tick) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + 10'd1;
        end
    end

    assign step = (sel == 2'd3) ? carry : rate_tick;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= SEED;
        end else if (step) begin
            lfsr <= {lfsr[29:0], lfsr[2] ^ lfsr[30]};
        end
    end

    assign noise = lfsr[0];

endmodule

/* src/saa_channel_mixer.sv */
module saa_channel_mixer import saa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tone,
    input  logic      noise,
    input  chan_cfg_t cfg,
    output level_t    level_l,
    output level_t    level_r
);

    logic   tone_on;
    logic   noise_on;
    level_t next_l;
    level_t next_r;

    assign tone_on  = cfg.tone_en && tone;
    assign noise_on = cfg.noise_en && noise;

    // amplitude counts once for tone, once more for noise
    assign next_l = (tone_on  ? level_t'(cfg.amp_l) : '0)
                  + (noise_on ? level_t'(cfg.amp_l) : '0);
    assign next_r = (tone_on  ? level_t'(cfg.amp_r) : '0)
                  + (noise_on ? level_t'(cfg.amp_r) : '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_l <= '0;
            level_r <= '0;
        end else begin
            level_l <= next_l;
            level_r <= next_r;
        end
    end

endmodule

/* src/saa_output_mixer.sv */
module saa_output_mixer import saa_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         sound_en,
    input  level_t [5:0] levels,
    output byte_t        sample
);

    byte_t sum;
    byte_t curved;

    // six channels at most 30 each, fits a byte
    always_comb begin
        sum = '0;
        if (sound_en) begin
            for (int i = 0; i < 6; i++) begin
                sum = sum + byte_t'(levels[i]);
            end
        end
    end

    // compressing transfer curve
    always_comb begin
        if (sum > COMP_KNEE) begin
            curved = COMP_KNEE + ((sum - COMP_KNEE) >> 1);
        end else begin
            curved = sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample <= '0;
        end else begin
            sample <= curved;
        end
    end

endmodule

/* src/saa1099_top.sv */
module saa1099_top import saa_pkg::*; #(
    parameter logic [30:0] SEED = DEFAULT_SEED
) (
    input  logic     clk,
    input  logic     rst_n,
    input  saa_bus_t bus,
    output byte_t    out_l,
    output byte_t    out_r
);

    saa_cfg_t     cfg;
    logic [5:0]   tone;
    logic [5:0]   carry;
    logic [1:0]   noise;
    level_t [5:0] level_l;
    level_t [5:0] level_r;

    saa_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus),
        .cfg   (cfg)
    );

    //////////////////////////////////////////////////////////////////////
    // tone generators and channel mixers
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < 6; i++) begin : g_chan
        saa_tone_gen u_tone (
            .clk    (clk),
            .rst_n  (rst_n),
            .sync   (cfg.sync),
            .octave (cfg.chan[i].octave),
            .freq   (cfg.chan[i].freq),
            .tone   (tone[i]),
            .carry  (carry[i])
        );

        // channels 0..2 share noise 0, 3..5 share noise 1
        saa_channel_mixer u_mix (
            .clk     (clk),
            .rst_n   (rst_n),
            .tone    (tone[i]),
            .noise   (noise[i / 3]),
            .cfg     (cfg.chan[i]),
            .level_l (level_l[i]),
            .level_r (level_r[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // noise generators, clocked by gens 0 and 3 when selected
    //////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < 2; n++) begin : g_noise
        saa_noise_gen #(
            .SEED (SEED)
        ) u_noise (
            .clk   (clk),
            .rst_n (rst_n),
            .carry (carry[n * 3]),
            .sel   (cfg.noise_sel[n]),
            .noise (noise[n])
        );
    end

    // final mix, one per side
    saa_output_mixer u_out_l (
        .clk      (clk),
        .rst_n    (rst_n),
        .sound_en (cfg.sound_en),
        .levels   (level_l),
        .sample   (out_l)
    );

    saa_output_mixer u_out_r (
        .clk      (clk),
        .rst_n    (rst_n),
        .sound_en (cfg.sound_en),
        .levels   (level_r),
        .sample   (out_r)
    );

endmodule

/* bench/saa_clock_gen.sv */
module saa_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held over two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* bench/saa_asserts.sv */
module saa_asserts import saa_pkg::*; (
    input logic         clk,
    input logic         rst_n,
    input saa_cfg_t     cfg,
    input logic [5:0]   carry,
    input level_t [5:0] level_l,
    input level_t [5:0] level_r,
    input byte_t        out_l,
    input byte_t        out_r
);

    timeunit 1ns;
    timeprecision 100ps;

    // output register lags sound_en by one cycle
    mute_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg.sound_en |=> (out_l == '0 && out_r == '0))
        else $error("output nonzero while sound is disabled");

    for (genvar i = 0; i < 6; i++) begin : g_chan
        carry_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            carry[i] |=> !carry[i])
            else $error("carry of tone generator %0d high for two cycles", i);

        // level is registered from the previous cycle's amplitude
        level_l_max: assert property (@(posedge clk) disable iff (!rst_n)
            level_l[i] <= {$past(cfg.chan[i].amp_l), 1'b0})
            else $error("left level of channel %0d above twice its amplitude", i);

        level_r_max: assert property (@(posedge clk) disable iff (!rst_n)
            level_r[i] <= {$past(cfg.chan[i].amp_r), 1'b0})
            else $error("right level of channel %0d above twice its amplitude", i);
    end

endmodule

/* bench/saa_tb.sv */
module saa_tb import saa_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned RAND_SEED = 32'hed8f_cf17;

    // register map of the chip
    localparam logic [4:0] ADDR_AMP0      = 5'h00;
    localparam logic [4:0] ADDR_FREQ0     = 5'h08;
    localparam logic [4:0] ADDR_OCT0      = 5'h10;
    localparam logic [4:0] ADDR_FREQ_EN   = 5'h14;
    localparam logic [4:0] ADDR_NOISE_EN  = 5'h15;
    localparam logic [4:0] ADDR_NOISE_GEN = 5'h16;
    localparam logic [4:0] ADDR_ENV0      = 5'h18;
    localparam logic [4:0] ADDR_ENV1      = 5'h19;
    localparam logic [4:0] ADDR_CTRL      = 5'h1c;

    localparam saa_bus_t BUS_IDLE = '{cs_n: 1'b1, a0: 1'b0, wr_n: 1'b1, din: 8'h00};

    // octave 7 and byte 255 give (511 - 255) prescaler periods of 256 >> 7 cycles
    localparam int HALF_CYCLES  = (511 - 255) * (256 >> 7);
    localparam int QUIET_CYCLES = 2100;
    localparam int NOISE_WINDOW = 4096;

    // worst case length of each test in cycles
    localparam int T_RESET = 3500;
    localparam int T_TONE  = 3300;
    localparam int T_KNEE  = 3300;
    localparam int T_NOISE = 4400;
    localparam int T_BLOCK = 3400;
    localparam int WATCHDOG_CYCLES = T_RESET + T_TONE + T_KNEE + T_NOISE + T_BLOCK + 1000;

    logic     clk;
    logic     rst_n;
    saa_bus_t bus;
    byte_t    out_l;
    byte_t    out_r;

    int errors;
    int checks;
    int tests;

    saa_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    saa1099_top #(
        .SEED (DEFAULT_SEED)
    ) dut (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus),
        .out_l (out_l),
        .out_r (out_r)
    );

    bind saa1099_top saa_asserts u_asserts (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .carry   (carry),
        .level_l (level_l),
        .level_r (level_r),
        .out_l   (out_l),
        .out_r   (out_r)
    );

    //////////////////////////////////////////////////////////////////////
    // checks and reporting
    //////////////////////////////////////////////////////////////////////

    task automatic check_sample(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("test %0s: passed", name);
        end else begin
            $display("test %0s: failed with %0d errors", name, errors - start);
        end
    endtask

    // output slope halves above a sum of 64
    function automatic byte_t compress_sum(input int sum);
        if (sum > 64) begin
            return byte_t'(64 + (sum - 64) / 2);
        end
        return byte_t'(sum);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bus and waiting helpers
    //////////////////////////////////////////////////////////////////////

    task automatic bus_write(input logic cs_n, input logic [4:0] addr, input byte_t data);
        @(posedge clk);
        bus <= '{cs_n: cs_n, a0: 1'b1, wr_n: 1'b0, din: {3'b000, addr}};
        @(posedge clk);
        bus <= '{cs_n: cs_n, a0: 1'b0, wr_n: 1'b0, din: data};
        @(posedge clk);
        bus <= BUS_IDLE;
    endtask

    task automatic write_reg(input logic [4:0] addr, input byte_t data);
        bus_write(1'b0, addr, data);
    endtask

    task automatic clear_regs();
        logic [4:0] ch;
        write_reg(ADDR_CTRL, 8'h00);
        write_reg(ADDR_FREQ_EN, 8'h00);
        write_reg(ADDR_NOISE_EN, 8'h00);
        write_reg(ADDR_NOISE_GEN, 8'h00);
        write_reg(ADDR_ENV0, 8'h00);
        write_reg(ADDR_ENV1, 8'h00);
        for (ch = 5'd0; ch < 5'd6; ch++) begin
            write_reg(ADDR_AMP0 + ch, 8'h00);
        end
    endtask

    task automatic expect_silence(input int cycles);
        int n;
        int first_err;
        first_err = errors;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            check_sample("out_l", out_l, 8'd0);
            check_sample("out_r", out_r, 8'd0);
            if (errors != first_err) begin
                break;
            end
        end
    endtask

    task automatic wait_nonzero(input int limit, output bit found);
        int n;
        found = 1'b0;
        for (n = 0; n < limit; n++) begin
            @(negedge clk);
            if (out_l != '0) begin
                found = 1'b1;
                break;
            end
        end
    endtask

    // counts samples while out_l stays on one side of zero
    task automatic measure_phase(input bit high, input byte_t exp_l, input byte_t exp_r,
                                 input int limit, output int cycles);
        cycles = 0;
        while (((out_l != '0) == high) && cycles < limit) begin
            check_sample("out_l", out_l, exp_l);
            check_sample("out_r", out_r, exp_r);
            cycles++;
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_and_mute();
        expect_silence(16);
        write_reg(ADDR_CTRL, 8'h00);
        write_reg(ADDR_AMP0 + 5'd2, 8'hff);
        write_reg(ADDR_OCT0 + 5'd1, 8'h07);
        write_reg(ADDR_FREQ0 + 5'd2, 8'hff);
        write_reg(ADDR_FREQ_EN, 8'h04);
        write_reg(ADDR_NOISE_EN, 8'h04);
        // leaves the address latch on ctrl
        write_reg(ADDR_CTRL, 8'h00);
        expect_silence(QUIET_CYCLES);
        // sound enable must not land while the chip is not selected
        bus_write(1'b1, ADDR_CTRL, 8'h01);
        expect_silence(QUIET_CYCLES / 2);
    endtask

    task automatic single_tone();
        amp_t amp_l;
        amp_t amp_r;
        bit   found;
        int   high_len;
        int   low_len;
        amp_l = amp_t'($urandom_range(15, 1));
        amp_r = amp_t'($urandom_range(15, 1));
        clear_regs();
        write_reg(ADDR_CTRL, 8'h02);
        write_reg(ADDR_AMP0 + 5'd2, {amp_r, amp_l});
        write_reg(ADDR_OCT0 + 5'd1, 8'h07);
        write_reg(ADDR_FREQ0 + 5'd2, 8'hff);
        write_reg(ADDR_FREQ_EN, 8'h04);
        write_reg(ADDR_CTRL, 8'h01);
        wait_nonzero(2 * HALF_CYCLES + 16, found);
        if (!found) begin
            report_failure("single tone never reached a high output level");
        end else begin
            measure_phase(1'b1, compress_sum(int'(amp_l)), compress_sum(int'(amp_r)),
                          2 * HALF_CYCLES, high_len);
            measure_phase(1'b0, 8'd0, 8'd0, 2 * HALF_CYCLES, low_len);
            check_count("high half period", high_len, HALF_CYCLES);
            check_count("low half period", low_len, HALF_CYCLES);
        end
    endtask

    task automatic all_channels_knee();
        logic [4:0] ch;
        byte_t      expected;
        bit         found;
        int         high_len;
        int         low_len;
        clear_regs();
        write_reg(ADDR_CTRL, 8'h02);
        for (ch = 5'd0; ch < 5'd6; ch++) begin
            write_reg(ADDR_AMP0 + ch, 8'hff);
            write_reg(ADDR_FREQ0 + ch, 8'hff);
        end
        write_reg(ADDR_OCT0, 8'h77);
        write_reg(ADDR_OCT0 + 5'd1, 8'h77);
        write_reg(ADDR_OCT0 + 5'd2, 8'h77);
        write_reg(ADDR_FREQ_EN, 8'h3f);
        write_reg(ADDR_CTRL, 8'h01);
        // six channels in phase at amplitude 15
        expected = compress_sum(6 * 15);
        wait_nonzero(2 * HALF_CYCLES + 16, found);
        if (!found) begin
            report_failure("six tone channels never reached a high output level");
        end else begin
            measure_phase(1'b1, expected, expected, 2 * HALF_CYCLES, high_len);
            measure_phase(1'b0, 8'd0, 8'd0, 2 * HALF_CYCLES, low_len);
            check_count("high half period", high_len, HALF_CYCLES);
            check_count("low half period", low_len, HALF_CYCLES);
        end
    endtask

    task automatic tone_with_noise();
        amp_t amp_l;
        amp_t amp_r;
        int   k;
        int   n;
        int   first_err;
        bit   saw_zero;
        bit   saw_sound;
        amp_l = amp_t'($urandom_range(15, 1));
        amp_r = amp_t'($urandom_range(15, 1));
        clear_regs();
        write_reg(ADDR_AMP0 + 5'd1, {amp_r, amp_l});
        write_reg(ADDR_OCT0, 8'h70);
        write_reg(ADDR_FREQ0 + 5'd1, 8'hff);
        write_reg(ADDR_FREQ_EN, 8'h02);
        write_reg(ADDR_NOISE_EN, 8'h02);
        write_reg(ADDR_CTRL, 8'h01);
        saw_zero = 1'b0;
        saw_sound = 1'b0;
        first_err = errors;
        for (n = 0; n < NOISE_WINDOW; n++) begin
            @(negedge clk);
            // 0, 1 or 2 amplitudes with the same count on both sides
            k = int'(out_l) / int'(amp_l);
            if (k > 2) begin
                k = 2;
            end
            check_sample("out_l", out_l, byte_t'(k * int'(amp_l)));
            check_sample("out_r", out_r, byte_t'(k * int'(amp_r)));
            if (out_l == '0) begin
                saw_zero = 1'b1;
            end else begin
                saw_sound = 1'b1;
            end
            if (errors != first_err) begin
                break;
            end
        end
        if (!saw_zero) begin
            report_failure("output never returned to zero with tone and noise on");
        end
        if (!saw_sound) begin
            report_failure("output never left zero with tone and noise on");
        end
    endtask

    task automatic tone_blocking();
        bit found;
        clear_regs();
        write_reg(ADDR_AMP0, 8'hff);
        write_reg(ADDR_AMP0 + 5'd1, 8'hff);
        write_reg(ADDR_OCT0, 8'h77);
        write_reg(ADDR_FREQ0, 8'hff);
        write_reg(ADDR_FREQ0 + 5'd1, 8'hff);
        // noise 0 clocked by gen 0 and envelope 0 takes gen 1
        write_reg(ADDR_NOISE_GEN, 8'h03);
        write_reg(ADDR_ENV0, 8'h80);
        write_reg(ADDR_FREQ_EN, 8'h03);
        write_reg(ADDR_CTRL, 8'h01);
        expect_silence(QUIET_CYCLES);
        write_reg(ADDR_NOISE_GEN, 8'h00);
        write_reg(ADDR_ENV0, 8'h00);
        wait_nonzero(2 * HALF_CYCLES + 16, found);
        if (!found) begin
            report_failure("tones of channels 0 and 1 did not return after unblocking");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        int start;
        bus = BUS_IDLE;
        errors = 0;
        checks = 0;
        tests = 0;
        void'($urandom(RAND_SEED));
        wait (rst_n === 1'b1);
        @(posedge clk);

        start = errors;
        reset_and_mute();
        report_test("reset and mute", start);
        start = errors;
        single_tone();
        report_test("single tone", start);
        start = errors;
        all_channels_knee();
        report_test("six channels at the knee", start);
        start = errors;
        tone_with_noise();
        report_test("tone with noise", start);
        start = errors;
        tone_blocking();
        report_test("tone blocking", start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* all.f */
src/saa_pkg.sv
src/saa_regfile.sv
src/saa_tone_gen.sv
src/saa_noise_gen.sv
src/saa_channel_mixer.sv
src/saa_output_mixer.sv
src/saa1099_top.sv
bench/saa_clock_gen.sv
bench/saa_asserts.sv
bench/saa_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module saa_tb \
    -f all.f -o saa_sim || exit 1
./obj_dir/saa_sim > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
